// File: ft245_cfg.svh
`ifndef FT245_CFG_SVH
`define FT245_CFG_SVH

// Width of one user data word
`define FT_WORD_BITS 32

// Bytes packed into one word, sent most significant first
`define FT_WORD_BYTES 4

// Words held by each ping-pong buffer
`define FT_FIFO_DEPTH 16

// Width of size and count fields on the FIFO handshake
`define FT_SIZE_BITS 24

`endif

// File: ft245_pkg.sv
`default_nettype none

package ft245_pkg;

  // One byte on the FT245 data bus
  typedef logic [7:0] ft_byte_t;

  // Host interface sequencer states
  typedef enum logic [3:0] {
    IDLE                    = 4'd0,
    INGRESS_READ            = 4'd1,
    EGRESS_PREPARE          = 4'd2,
    EGRESS_SEND             = 4'd3,
    EGRESS_SEND_TEMP_DATA   = 4'd4,
    EGRESS_SEND_IMMEDIATELY = 4'd5
  } host_state_t;

endpackage

`default_nettype wire

// File: fifo_pkg.sv
`default_nettype none

`include "ft245_cfg.svh"

package fifo_pkg;

  typedef logic [`FT_WORD_BITS-1:0] word_t;
  typedef logic [`FT_SIZE_BITS-1:0] size_t;

  // One bit per ping-pong buffer
  typedef logic [1:0] buf_sel_t;

endpackage

`default_nettype wire

// File: ft245_host_interface.sv
`timescale 1ns/1ns
`default_nettype none

`include "ft245_cfg.svh"

module ft245_host_interface (
  input  wire                      i_ft245_clk,
  input  wire                      rst,
  input  wire                      i_ft245_txe_n,
  input  wire                      i_ft245_rde_n,
  inout  wire ft245_pkg::ft_byte_t io_ft245_data,
  output logic                     o_ft245_wr_n,
  output logic                     o_ft245_rd_n,
  output logic                     o_ft245_oe_n,
  output logic                     o_ft245_siwu,
  // Ingress FIFO write side
  input  wire fifo_pkg::buf_sel_t  i_ing_rdy,
  output fifo_pkg::buf_sel_t       o_ing_act,
  input  wire fifo_pkg::size_t     i_ing_size,
  output logic                     o_ing_stb,
  output fifo_pkg::word_t          o_ing_data,
  // Egress FIFO read side
  input  wire                      i_egr_rdy,
  output logic                     o_egr_act,
  input  wire fifo_pkg::size_t     i_egr_size,
  output logic                     o_egr_stb,
  input  wire fifo_pkg::word_t     i_egr_data
);

  localparam int WB = `FT_WORD_BITS;
  localparam int BC_BITS = $clog2(`FT_WORD_BYTES) + 1;
  localparam logic [BC_BITS-1:0] LAST_BYTE = BC_BITS'(`FT_WORD_BYTES - 1);
  localparam logic [BC_BITS-1:0] ALL_BYTES = BC_BITS'(`FT_WORD_BYTES);

  ft245_pkg::host_state_t state;
  fifo_pkg::size_t        count;
  logic [BC_BITS-1:0]     byte_count;

  logic oe;
  logic rd_stb;
  logic wr_stb;
  logic siwu_stb;
  logic use_hold;

  fifo_pkg::word_t     ing_word;
  fifo_pkg::word_t     egr_word;
  ft245_pkg::ft_byte_t tx_byte;
  ft245_pkg::ft_byte_t hold_byte;

  logic rde_avail;
  logic txe_avail;
  logic rd_take;
  logic ing_last;
  logic ing_wait;
  logic send_refuse;
  logic send_shift;
  logic send_fetch;

  assign rde_avail = !i_ft245_rde_n;
  assign txe_avail = !i_ft245_txe_n;

  assign o_ft245_wr_n = !wr_stb;
  assign o_ft245_rd_n = !rd_stb;
  assign o_ft245_oe_n = !oe;
  assign o_ft245_siwu = !siwu_stb;

  // Chip owns the bus while oe is asserted
  assign io_ft245_data = oe ? 8'hzz : (use_hold ? hold_byte : tx_byte);

  assign rd_take  = rd_stb && rde_avail;
  // Final byte of the word that fills the claimed buffer
  assign ing_last = rd_take && (byte_count == LAST_BYTE) && (count + 1'b1 == i_ing_size);
  // Host has data and a buffer can be claimed for it
  assign ing_wait = rde_avail && (i_ing_rdy != 2'b00);

  assign send_refuse = (state == ft245_pkg::EGRESS_SEND) && wr_stb && i_ft245_txe_n;
  assign send_shift  = (state == ft245_pkg::EGRESS_SEND) && !send_refuse &&
                       (byte_count < ALL_BYTES);
  assign send_fetch  = (state == ft245_pkg::EGRESS_SEND) && !send_refuse &&
                       (byte_count == ALL_BYTES) && (count < i_egr_size);

  always_ff @(posedge i_ft245_clk) begin
    if (rst) begin
      state      <= ft245_pkg::IDLE;
      count      <= '0;
      byte_count <= '0;
      oe         <= 1'b0;
      rd_stb     <= 1'b0;
      wr_stb     <= 1'b0;
      siwu_stb   <= 1'b0;
      use_hold   <= 1'b0;
      o_ing_act  <= '0;
      o_ing_stb  <= 1'b0;
      o_egr_act  <= 1'b0;
      o_egr_stb  <= 1'b0;
    end else begin
      rd_stb    <= 1'b0;
      wr_stb    <= 1'b0;
      siwu_stb  <= 1'b0;
      o_ing_stb <= 1'b0;
      o_egr_stb <= 1'b0;
      case (state)
        ft245_pkg::IDLE: begin
          count      <= '0;
          byte_count <= '0;
          oe         <= 1'b0;
          use_hold   <= 1'b0;
          if ((o_ing_act == 2'b00) && (i_ing_rdy != 2'b00)) begin
            o_ing_act <= i_ing_rdy[0] ? 2'b01 : 2'b10;
          end
          // Ingress wins whenever it can make progress
          if (rde_avail && (o_ing_act != 2'b00)) begin
            oe    <= 1'b1;
            state <= ft245_pkg::INGRESS_READ;
          end else if (i_egr_rdy && !ing_wait) begin
            o_egr_act <= 1'b1;
            state     <= ft245_pkg::EGRESS_PREPARE;
          end
        end
        ft245_pkg::INGRESS_READ: begin
          if (rd_take) begin
            if (byte_count == LAST_BYTE) begin
              byte_count <= '0;
              count      <= count + 1'b1;
              o_ing_stb  <= 1'b1;
            end else begin
              byte_count <= byte_count + 1'b1;
            end
          end
          // Leave on a full buffer or a word boundary with no more data
          if ((count >= i_ing_size) || (!rde_avail && (byte_count == '0))) begin
            o_ing_act <= '0;
            oe        <= 1'b0;
            state     <= ft245_pkg::IDLE;
          end else if (rde_avail && !ing_last) begin
            rd_stb <= 1'b1;
          end
        end
        ft245_pkg::EGRESS_PREPARE: begin
          count      <= fifo_pkg::size_t'(1);
          byte_count <= '0;
          o_egr_stb  <= 1'b1;
          state      <= ft245_pkg::EGRESS_SEND;
        end
        ft245_pkg::EGRESS_SEND: begin
          if (send_refuse) begin
            use_hold <= 1'b1;
            state    <= ft245_pkg::EGRESS_SEND_TEMP_DATA;
          end else if (send_shift) begin
            byte_count <= byte_count + 1'b1;
            wr_stb     <= 1'b1;
            use_hold   <= 1'b0;
          end else if (send_fetch) begin
            byte_count <= BC_BITS'(1);
            count      <= count + 1'b1;
            o_egr_stb  <= 1'b1;
            wr_stb     <= 1'b1;
            use_hold   <= 1'b0;
          end else begin
            // Last byte went out, release the buffer
            o_egr_act <= 1'b0;
            use_hold  <= 1'b0;
            state     <= ft245_pkg::EGRESS_SEND_IMMEDIATELY;
          end
        end
        ft245_pkg::EGRESS_SEND_TEMP_DATA: begin
          // Resend the refused byte once the chip has room
          if (txe_avail) begin
            wr_stb <= 1'b1;
            state  <= ft245_pkg::EGRESS_SEND;
          end
        end
        ft245_pkg::EGRESS_SEND_IMMEDIATELY: begin
          siwu_stb <= 1'b1;
          state    <= ft245_pkg::IDLE;
        end
        default: begin
          state <= ft245_pkg::IDLE;
        end
      endcase
    end
  end

  // Byte shifters, MSB first
  always_ff @(posedge i_ft245_clk) begin
    if (rd_take) begin
      ing_word <= {ing_word[WB-9:0], io_ft245_data};
    end
    if (rd_take && (byte_count == LAST_BYTE)) begin
      o_ing_data <= {ing_word[WB-9:0], io_ft245_data};
    end
    if (state == ft245_pkg::EGRESS_PREPARE) begin
      egr_word <= i_egr_data;
    end else if (send_shift) begin
      tx_byte  <= egr_word[WB-1 -: 8];
      egr_word <= egr_word << 8;
    end else if (send_fetch) begin
      tx_byte  <= i_egr_data[WB-1 -: 8];
      egr_word <= i_egr_data << 8;
    end
    if (send_refuse) begin
      hold_byte <= use_hold ? hold_byte : tx_byte;
    end
  end

endmodule

`default_nettype wire

// File: ppfifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "ft245_cfg.svh"

module ppfifo #(
  parameter int DEPTH = `FT_FIFO_DEPTH
) (
  input  wire                     i_ft245_clk,
  input  wire                     rst,
  // Write side
  output fifo_pkg::buf_sel_t      o_wr_rdy,
  input  wire fifo_pkg::buf_sel_t i_wr_act,
  output fifo_pkg::size_t         o_wr_size,
  input  wire                     i_wr_stb,
  input  wire fifo_pkg::word_t    i_wr_data,
  // Read side
  output logic                    o_rd_rdy,
  input  wire                     i_rd_act,
  output fifo_pkg::size_t         o_rd_size,
  input  wire                     i_rd_stb,
  output fifo_pkg::word_t         o_rd_data
);

  localparam int ADDR_BITS = $clog2(DEPTH);
  localparam fifo_pkg::size_t BUF_WORDS = fifo_pkg::size_t'(DEPTH);

  fifo_pkg::word_t    mem [2][DEPTH];
  fifo_pkg::size_t    count [2];
  logic [1:0]         full;
  fifo_pkg::buf_sel_t wr_act_q;
  logic               rd_act_q;
  // Older of the two buffers, always the next one read
  logic               first;
  logic [ADDR_BITS-1:0] rd_ptr;

  logic       wr_sel;
  logic       wr_en;
  logic [1:0] fill;
  logic       release_buf;

  assign wr_sel = i_wr_act[1];
  assign wr_en  = i_wr_stb && (i_wr_act != 2'b00) && (count[wr_sel] < BUF_WORDS);

  // A buffer closes with data when its act bit drops
  assign fill[0] = wr_act_q[0] && !i_wr_act[0] && (count[0] != '0);
  assign fill[1] = wr_act_q[1] && !i_wr_act[1] && (count[1] != '0);
  assign release_buf = rd_act_q && !i_rd_act;

  assign o_wr_rdy  = ~full & ~wr_act_q;
  assign o_wr_size = BUF_WORDS;

  assign o_rd_rdy  = full[first] && !rd_act_q;
  assign o_rd_size = count[first];
  // First word falls through
  assign o_rd_data = mem[first][rd_ptr];

  always_ff @(posedge i_ft245_clk) begin
    if (rst) begin
      full     <= '0;
      wr_act_q <= '0;
      rd_act_q <= 1'b0;
      first    <= 1'b0;
      rd_ptr   <= '0;
      count[0] <= '0;
      count[1] <= '0;
    end else begin
      wr_act_q <= i_wr_act;
      rd_act_q <= i_rd_act;
      if (wr_en) begin
        count[wr_sel] <= count[wr_sel] + 1'b1;
      end
      if (i_rd_act && i_rd_stb) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (fill[0]) begin
        full[0] <= 1'b1;
      end
      if (fill[1]) begin
        full[1] <= 1'b1;
      end
      if (release_buf) begin
        full[first]  <= 1'b0;
        count[first] <= '0;
        rd_ptr       <= '0;
        // Hand over to the other buffer if it holds data
        if (full[!first] || fill[!first]) begin
          first <= !first;
        end
      end else if (fill[0] && !full[1]) begin
        first <= 1'b0;
      end else if (fill[1] && !full[0]) begin
        first <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_ft245_clk) begin
    if (wr_en) begin
      mem[wr_sel][count[wr_sel][ADDR_BITS-1:0]] <= i_wr_data;
    end
  end

endmodule

`default_nettype wire

// File: ft245_bridge_top.sv
`timescale 1ns/1ns
`default_nettype none

module ft245_bridge_top (
  input  wire                      i_ft245_clk,
  input  wire                      rst,
  // FT245 pins
  input  wire                      i_ft245_txe_n,
  input  wire                      i_ft245_rde_n,
  inout  wire ft245_pkg::ft_byte_t io_ft245_data,
  output wire                      o_ft245_wr_n,
  output wire                      o_ft245_rd_n,
  output wire                      o_ft245_oe_n,
  output wire                      o_ft245_siwu,
  // Ingress words to user logic
  output wire                      o_in_rdy,
  input  wire                      i_in_act,
  output wire fifo_pkg::size_t     o_in_size,
  input  wire                      i_in_stb,
  output wire fifo_pkg::word_t     o_in_data,
  // Egress words from user logic
  output wire fifo_pkg::buf_sel_t  o_out_rdy,
  input  wire fifo_pkg::buf_sel_t  i_out_act,
  output wire fifo_pkg::size_t     o_out_size,
  input  wire                      i_out_stb,
  input  wire fifo_pkg::word_t     i_out_data
);

  wire fifo_pkg::buf_sel_t ing_rdy;
  wire fifo_pkg::buf_sel_t ing_act;
  wire fifo_pkg::size_t    ing_size;
  wire                     ing_stb;
  wire fifo_pkg::word_t    ing_data;

  wire                     egr_rdy;
  wire                     egr_act;
  wire fifo_pkg::size_t    egr_size;
  wire                     egr_stb;
  wire fifo_pkg::word_t    egr_data;

  ft245_host_interface host_if (
    .i_ft245_clk   (i_ft245_clk),
    .rst           (rst),
    .i_ft245_txe_n (i_ft245_txe_n),
    .i_ft245_rde_n (i_ft245_rde_n),
    .io_ft245_data (io_ft245_data),
    .o_ft245_wr_n  (o_ft245_wr_n),
    .o_ft245_rd_n  (o_ft245_rd_n),
    .o_ft245_oe_n  (o_ft245_oe_n),
    .o_ft245_siwu  (o_ft245_siwu),
    .i_ing_rdy     (ing_rdy),
    .o_ing_act     (ing_act),
    .i_ing_size    (ing_size),
    .o_ing_stb     (ing_stb),
    .o_ing_data    (ing_data),
    .i_egr_rdy     (egr_rdy),
    .o_egr_act     (egr_act),
    .i_egr_size    (egr_size),
    .o_egr_stb     (egr_stb),
    .i_egr_data    (egr_data)
  );

  // Host to user
  ppfifo ingress_fifo (
    .i_ft245_clk (i_ft245_clk),
    .rst         (rst),
    .o_wr_rdy    (ing_rdy),
    .i_wr_act    (ing_act),
    .o_wr_size   (ing_size),
    .i_wr_stb    (ing_stb),
    .i_wr_data   (ing_data),
    .o_rd_rdy    (o_in_rdy),
    .i_rd_act    (i_in_act),
    .o_rd_size   (o_in_size),
    .i_rd_stb    (i_in_stb),
    .o_rd_data   (o_in_data)
  );

  // User to host
  ppfifo egress_fifo (
    .i_ft245_clk (i_ft245_clk),
    .rst         (rst),
    .o_wr_rdy    (o_out_rdy),
    .i_wr_act    (i_out_act),
    .o_wr_size   (o_out_size),
    .i_wr_stb    (i_out_stb),
    .i_wr_data   (i_out_data),
    .o_rd_rdy    (egr_rdy),
    .i_rd_act    (egr_act),
    .o_rd_size   (egr_size),
    .i_rd_stb    (egr_stb),
    .o_rd_data   (egr_data)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic o_clk
);

  // 40 ns period
  initial begin
    o_clk = 1'b0;
  end

  always #20 o_clk = ~o_clk;

endmodule

`default_nettype wire

// File: ft245_chip_model.sv
`timescale 1ns/1ns
`default_nettype none

module ft245_chip_model (
  input  wire       i_ft245_clk,
  input  wire       i_stall_en,
  output logic      o_ft245_txe_n,
  output wire       o_ft245_rde_n,
  inout  wire [7:0] io_ft245_data,
  input  wire       i_ft245_wr_n,
  input  wire       i_ft245_rd_n,
  input  wire       i_ft245_oe_n,
  input  wire       i_ft245_siwu
);

  // Bytes waiting to go to the bridge
  logic [7:0] rx_mem [0:4095];
  int         rx_head = 0;
  int         rx_tail = 0;

  // Bytes taken from the bridge
  logic [7:0] tx_mem [0:4095];
  int         tx_count = 0;

  // SIWU pulse tracking
  int siwu_pulses = 0;
  int siwu_len = 0;
  int low_run = 0;
  int pulse_tx_count = 0;

  integer seed = 32'h8dfc_3069;

  initial begin
    o_ft245_txe_n = 1'b1;
  end

  assign o_ft245_rde_n = (rx_head == rx_tail);
  assign io_ft245_data = i_ft245_oe_n ? 8'hzz : rx_mem[rx_head];

  task automatic push_rx_byte(input logic [7:0] b);
    rx_mem[rx_tail] = b;
    rx_tail = rx_tail + 1;
  endtask

  always @(posedge i_ft245_clk) begin
    if (!i_ft245_rd_n && !o_ft245_rde_n) begin
      rx_head <= rx_head + 1;
    end
    if (!i_ft245_wr_n && !o_ft245_txe_n) begin
      tx_mem[tx_count] <= io_ft245_data;
      tx_count         <= tx_count + 1;
    end
    // Length of each low pulse, and how many bytes came before it
    if (!i_ft245_siwu) begin
      if (low_run == 0) begin
        pulse_tx_count <= tx_count;
      end
      low_run <= low_run + 1;
    end else if (low_run != 0) begin
      siwu_len    <= low_run;
      siwu_pulses <= siwu_pulses + 1;
      low_run     <= 0;
    end
    // Roughly one cycle in four is busy when stalls are on
    o_ft245_txe_n <= i_stall_en && (($random(seed) & 3) == 0);
  end

endmodule

`default_nettype wire

// File: tb_ft245_bridge.sv
`timescale 1ns/1ns
`default_nettype none

`include "ft245_cfg.svh"

module tb_ft245_bridge;

  localparam int TIMEOUT = 4000;
  localparam int DEPTH = `FT_FIFO_DEPTH;

  wire                clk;
  logic               rst;
  logic               i_in_act;
  logic               i_in_stb;
  fifo_pkg::buf_sel_t i_out_act;
  logic               i_out_stb;
  fifo_pkg::word_t    i_out_data;
  logic               stall_en;

  wire                     txe_n;
  wire                     rde_n;
  wire [7:0]               ft_data;
  wire                     wr_n;
  wire                     rd_n;
  wire                     oe_n;
  wire                     siwu;
  wire                     o_in_rdy;
  wire fifo_pkg::size_t    o_in_size;
  wire fifo_pkg::word_t    o_in_data;
  wire fifo_pkg::buf_sel_t o_out_rdy;
  wire fifo_pkg::size_t    o_out_size;

  int              errors;
  int              timeouts;
  int              records;
  bit              aborted;
  fifo_pkg::word_t words [0:63];

  tb_clock_gen clock_gen (
    .o_clk (clk)
  );

  ft245_chip_model chip_model (
    .i_ft245_clk   (clk),
    .i_stall_en    (stall_en),
    .o_ft245_txe_n (txe_n),
    .o_ft245_rde_n (rde_n),
    .io_ft245_data (ft_data),
    .i_ft245_wr_n  (wr_n),
    .i_ft245_rd_n  (rd_n),
    .i_ft245_oe_n  (oe_n),
    .i_ft245_siwu  (siwu)
  );

  ft245_bridge_top ft245_bridge_top_i (
    .i_ft245_clk   (clk),
    .rst           (rst),
    .i_ft245_txe_n (txe_n),
    .i_ft245_rde_n (rde_n),
    .io_ft245_data (ft_data),
    .o_ft245_wr_n  (wr_n),
    .o_ft245_rd_n  (rd_n),
    .o_ft245_oe_n  (oe_n),
    .o_ft245_siwu  (siwu),
    .o_in_rdy      (o_in_rdy),
    .i_in_act      (i_in_act),
    .o_in_size     (o_in_size),
    .i_in_stb      (i_in_stb),
    .o_in_data     (o_in_data),
    .o_out_rdy     (o_out_rdy),
    .i_out_act     (i_out_act),
    .o_out_size    (o_out_size),
    .i_out_stb     (i_out_stb),
    .i_out_data    (i_out_data)
  );

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    timeouts++;
    aborted = 1'b1;
  endtask

  // Host sends the words MSB first, then user side drains the ingress FIFO
  task automatic run_ingress(input int n);
    int idx;
    int chunk;
    int k;
    int b;
    int wait_n;
    for (k = 0; k < n; k++) begin
      for (b = 3; b >= 0; b--) begin
        chip_model.push_rx_byte(words[k][8*b +: 8]);
      end
    end
    idx = 0;
    while (idx < n && !aborted) begin
      wait_n = 0;
      while (!o_in_rdy && wait_n < TIMEOUT) begin
        @(negedge clk);
        wait_n++;
      end
      if (!o_in_rdy) begin
        report_timeout("an ingress packet");
      end else begin
        chunk = (n - idx > DEPTH) ? DEPTH : n - idx;
        i_in_act = 1'b1;
        @(negedge clk);
        if (o_in_size !== fifo_pkg::size_t'(chunk)) begin
          $display("ERROR o_in_size: got %h expected %h", o_in_size, chunk);
          errors++;
        end
        for (k = 0; k < chunk; k++) begin
          if (o_in_data !== words[idx + k]) begin
            $display("ERROR o_in_data: got %h expected %h", o_in_data, words[idx + k]);
            errors++;
          end
          i_in_stb = 1'b1;
          @(negedge clk);
        end
        i_in_stb = 1'b0;
        i_in_act = 1'b0;
        @(negedge clk);
        idx += chunk;
      end
    end
  endtask

  // User side fills one egress buffer and the chip model captures the bytes
  task automatic run_egress(input int n, input int stall);
    int k;
    int wait_n;
    int tx_start;
    int pulses_start;
    logic [7:0] exp_byte;
    tx_start = chip_model.tx_count;
    pulses_start = chip_model.siwu_pulses;
    stall_en = (stall != 0);
    wait_n = 0;
    while (o_out_rdy == 2'b00 && wait_n < TIMEOUT) begin
      @(negedge clk);
      wait_n++;
    end
    if (o_out_rdy == 2'b00) begin
      report_timeout("a free egress buffer");
      return;
    end
    // Each buffer takes a full DEPTH words
    if (o_out_size !== fifo_pkg::size_t'(DEPTH)) begin
      $display("ERROR o_out_size: got %h expected %h", o_out_size, DEPTH);
      errors++;
    end
    i_out_act = o_out_rdy[0] ? 2'b01 : 2'b10;
    for (k = 0; k < n; k++) begin
      i_out_data = words[k];
      i_out_stb = 1'b1;
      @(negedge clk);
    end
    i_out_stb = 1'b0;
    i_out_act = 2'b00;
    wait_n = 0;
    while (chip_model.siwu_pulses == pulses_start && wait_n < TIMEOUT) begin
      @(negedge clk);
      wait_n++;
    end
    stall_en = 1'b0;
    if (chip_model.siwu_pulses == pulses_start) begin
      report_timeout("the SIWU pulse");
      return;
    end
    if (chip_model.siwu_len !== 1) begin
      $display("ERROR o_ft245_siwu low cycles: got %h expected %h", chip_model.siwu_len, 1);
      errors++;
    end
    if (chip_model.pulse_tx_count - tx_start !== 4 * n) begin
      $display("ERROR io_ft245_data byte count: got %h expected %h",
               chip_model.pulse_tx_count - tx_start, 4 * n);
      errors++;
    end
    for (k = 0; k < 4 * n; k++) begin
      exp_byte = words[k / 4][8 * (3 - k % 4) +: 8];
      if (chip_model.tx_mem[tx_start + k] !== exp_byte) begin
        $display("ERROR io_ft245_data: got %h expected %h",
                 chip_model.tx_mem[tx_start + k], exp_byte);
        errors++;
      end
    end
  endtask

  initial begin
    int fd;
    int code;
    int n;
    int stall;
    int k;
    reg [8*200-1:0] line;
    reg [63:0] dir;
    rst = 1'b1;
    i_in_act = 1'b0;
    i_in_stb = 1'b0;
    i_out_act = 2'b00;
    i_out_stb = 1'b0;
    i_out_data = '0;
    stall_en = 1'b0;
    errors = 0;
    timeouts = 0;
    records = 0;
    aborted = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    if ({wr_n, rd_n, oe_n, siwu} !== 4'hf) begin
      $display("ERROR wr_n/rd_n/oe_n/siwu: got %h expected %h", {wr_n, rd_n, oe_n, siwu}, 4'hf);
      errors++;
    end
    if (o_in_rdy !== 1'b0) begin
      $display("ERROR o_in_rdy: got %h expected %h", o_in_rdy, 1'b0);
      errors++;
    end
    if (o_out_rdy !== 2'b11) begin
      $display("ERROR o_out_rdy: got %h expected %h", o_out_rdy, 2'b11);
      errors++;
    end

    fd = $fopen("ft245_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file ft245_tests.txt");
      errors++;
    end else begin
      while (!aborted && !$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0) begin
          code = $sscanf(line, "%s %d %d", dir, n, stall);
          if (code == 3) begin
            for (k = 0; k < n; k++) begin
              code = $fscanf(fd, "%h", words[k]);
            end
            records++;
            if (dir == "I") begin
              run_ingress(n);
            end else begin
              run_egress(n, stall);
            end
          end
        end
      end
      $fclose(fd);
      if (records == 0) begin
        $display("No test records were found in the data file");
        errors++;
      end
    end

    $display("Done: %0d records, %0d value errors, %0d timeouts", records, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ft245_tests.txt
# dir count stall: I = host to user, E = user to host, stall 1 = random txe_n
# words in hex follow on the next lines, first word first
I 1 0
11223344
I 4 0
a0a1a2a3 b0b1b2b3 c0c1c2c3 d0d1d2d3
E 3 0
01020304 05060708 090a0b0c
E 8 1
deadbeef 00ff00ff 12345678 9abcdef0 cafef00d 0badc0de 55aa55aa 7f80817e
I 20 0
00010203 04050607 08090a0b 0c0d0e0f 10111213 14151617 18191a1b 1c1d1e1f 20212223 24252627
28292a2b 2c2d2e2f 30313233 34353637 38393a3b 3c3d3e3f 40414243 44454647 48494a4b 4c4d4e4f
E 16 1
f0e1d2c3 b4a59687 78695a4b 3c2d1e0f 11111111 22222222 33333333 44444444
a5a5a5a5 5a5a5a5a 01234567 89abcdef fedcba98 76543210 80000001 7ffffffe

// File: project.f
+incdir+.
ft245_pkg.sv
fifo_pkg.sv
ft245_host_interface.sv
ppfifo.sv
ft245_bridge_top.sv
tb_clock_gen.sv
ft245_chip_model.sv
tb_ft245_bridge.sv
